//--- mipsPkg.sv
package mipsPkg;
    typedef logic [31:0] dataT;    // data word, address or pc
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  byteEnT;  // one bit per byte lane

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr,
        aluXor, aluNor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui
    } aluOpE;

    typedef enum logic [2:0] {
        memNone, memLw, memLb, memLbu, memSw, memSb
    } memOpE;

    typedef enum logic {
        fwdRegFile, fwdResultM
    } forwardSelE;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLbu     = 6'b100100;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSw      = 6'b101011;

    // function field of special
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;
endpackage

//--- instDecoder.sv
module instDecoder (
    input  mipsPkg::instrT   instr,
    output mipsPkg::regAddrT rsAddr,
    output mipsPkg::regAddrT rtAddr,
    output mipsPkg::regAddrT destAddr,
    output logic             regWriteEn,
    output mipsPkg::aluOpE   aluOp,
    output logic             aluSrcImm,
    output mipsPkg::dataT    imm,
    output logic [4:0]       shamt,
    output mipsPkg::memOpE   memOp
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       useRd;    // r-type writes rd
    logic       writes;
    logic       zeroExt;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign shamt  = instr[10:6];

    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b1;
        memOp     = memNone;
        useRd     = 1'b0;
        writes    = 1'b0;
        zeroExt   = 1'b0;
        case (opcode)
            opSpecial: begin
                aluSrcImm = 1'b0;
                useRd     = 1'b1;
                writes    = 1'b1;
                case (funct)
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    default: writes = 1'b0;  // unknown funct acts as a no-op
                endcase
            end
            opAddiu: writes = 1'b1;
            opSlti: begin
                aluOp  = aluSlt;
                writes = 1'b1;
            end
            opAndi: begin
                aluOp   = aluAnd;
                zeroExt = 1'b1;
                writes  = 1'b1;
            end
            opOri: begin
                aluOp   = aluOr;
                zeroExt = 1'b1;
                writes  = 1'b1;
            end
            opXori: begin
                aluOp   = aluXor;
                zeroExt = 1'b1;
                writes  = 1'b1;
            end
            opLui: begin
                aluOp  = aluLui;
                writes = 1'b1;
            end
            opLw: begin
                memOp  = memLw;
                writes = 1'b1;
            end
            opLb: begin
                memOp  = memLb;
                writes = 1'b1;
            end
            opLbu: begin
                memOp  = memLbu;
                writes = 1'b1;
            end
            opSw:    memOp = memSw;
            opSb:    memOp = memSb;
            default: writes = 1'b0;
        endcase
    end

    assign destAddr   = useRd ? instr[15:11] : instr[20:16];
    assign imm        = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign regWriteEn = writes && (destAddr != '0);  // r0 never written
endmodule

//--- regFile.sv
module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    input  mipsPkg::regAddrT writeAddr,
    input  logic             writeEn,
    input  mipsPkg::dataT    writeData,
    output mipsPkg::dataT    readDataA,
    output mipsPkg::dataT    readDataB
);
    import mipsPkg::*;

    dataT regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    function automatic dataT readPort(input regAddrT addr);
        dataT value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEn && addr == writeAddr) begin
            value = writeData;  // write-through from M
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end
endmodule

//--- hazardUnit.sv
module hazardUnit (
    input  mipsPkg::regAddrT    rsD,
    input  mipsPkg::regAddrT    rtD,
    input  mipsPkg::regAddrT    rsE,
    input  mipsPkg::regAddrT    rtE,
    input  mipsPkg::regAddrT    destE,
    input  mipsPkg::regAddrT    destM,
    input  mipsPkg::memOpE      memOpE,
    input  logic                regWriteEnE,
    input  logic                regWriteEnM,
    output logic                stallD,
    output mipsPkg::forwardSelE forwardA,
    output mipsPkg::forwardSelE forwardB
);
    import mipsPkg::*;

    logic loadE;

    function automatic forwardSelE selectSource(input regAddrT srcReg);
        forwardSelE sel;
        sel = fwdRegFile;
        if (regWriteEnM && destM == srcReg) begin
            sel = fwdResultM;
        end
        return sel;
    endfunction

    assign loadE = (memOpE == memLw) || (memOpE == memLb) || (memOpE == memLbu);

    // load result not ready until M so D holds one cycle
    assign stallD = loadE && regWriteEnE && (destE == rsD || destE == rtD);

    always_comb begin
        forwardA = selectSource(rsE);
        forwardB = selectSource(rtE);
    end
endmodule

//--- aluExecute.sv
module aluExecute (
    input  mipsPkg::dataT       rsValue,
    input  mipsPkg::dataT       rtValue,
    input  mipsPkg::dataT       resultM,
    input  mipsPkg::dataT       imm,
    input  mipsPkg::forwardSelE forwardA,
    input  mipsPkg::forwardSelE forwardB,
    input  mipsPkg::aluOpE      aluOp,
    input  logic                aluSrcImm,
    input  logic [4:0]          shamt,
    output mipsPkg::dataT       aluResult,
    output mipsPkg::dataT       storeData
);
    import mipsPkg::*;

    dataT srcA;
    dataT srcB;
    dataT rtFwd;  // rt after bypass

    assign srcA      = (forwardA == fwdResultM) ? resultM : rsValue;
    assign rtFwd     = (forwardB == fwdResultM) ? resultM : rtValue;
    assign srcB      = aluSrcImm ? imm : rtFwd;
    assign storeData = rtFwd;

    always_comb begin
        case (aluOp)
            aluAdd: begin
                aluResult = srcA + srcB;  // also load/store address
            end
            aluSub: begin
                aluResult = srcA - srcB;
            end
            aluAnd: begin
                aluResult = srcA & srcB;
            end
            aluOr: begin
                aluResult = srcA | srcB;
            end
            aluXor: begin
                aluResult = srcA ^ srcB;
            end
            aluNor: begin
                aluResult = ~(srcA | srcB);
            end
            aluSlt: begin
                aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            end
            aluSltu: begin
                aluResult = {31'b0, srcA < srcB};
            end
            // shifts act on rt by the shamt field
            aluSll:  aluResult = srcB << shamt;
            aluSrl:  aluResult = srcB >> shamt;
            aluSra:  aluResult = dataT'($signed(srcB) >>> shamt);
            aluLui:  aluResult = {srcB[15:0], 16'b0};
            default: aluResult = '0;
        endcase
    end
endmodule

//--- memAccess.sv
module memAccess (
    input  mipsPkg::memOpE  memOp,
    input  mipsPkg::dataT   aluResult,
    input  mipsPkg::dataT   storeData,
    input  mipsPkg::dataT   memRdata,
    output logic            memEn,
    output mipsPkg::dataT   memAddr,
    output mipsPkg::dataT   memWdata,
    output mipsPkg::dataT   result,
    output mipsPkg::byteEnT memWen
);
    import mipsPkg::*;

    logic       isLoad;
    logic       isStore;
    logic [1:0] lane;
    logic [7:0] loadByte;

    assign isLoad  = (memOp == memLw) || (memOp == memLb) || (memOp == memLbu);
    assign isStore = (memOp == memSw) || (memOp == memSb);
    assign memEn   = isLoad || isStore;
    assign memAddr = aluResult;
    assign lane    = aluResult[1:0];

    // store side
    always_comb begin
        memWen   = '0;
        memWdata = storeData;
        case (memOp)
            memSw: memWen = 4'b1111;
            memSb: begin
                memWen   = byteEnT'(4'b0001 << lane);
                memWdata = {4{storeData[7:0]}};  // byte on every lane
            end
            default: memWen = '0;
        endcase
    end

    assign loadByte = memRdata[{lane, 3'b000} +: 8];

    // committed value
    always_comb begin
        case (memOp)
            memLw:   result = memRdata;
            memLb:   result = {{24{loadByte[7]}}, loadByte};
            memLbu:  result = {24'b0, loadByte};
            default: result = aluResult;
        endcase
    end
endmodule

//--- coreDatapath.sv
module coreDatapath #(
    parameter mipsPkg::dataT resetPc = 32'hbfc0_0000
) (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::dataT    instrF,
    input  mipsPkg::dataT    memRdata,
    output mipsPkg::dataT    pcF,
    output logic             memEn,
    output mipsPkg::dataT    memAddr,
    output mipsPkg::dataT    memWdata,
    output mipsPkg::byteEnT  memWen,
    output mipsPkg::dataT    debugWbPc,
    output mipsPkg::byteEnT  debugWbRfWen,
    output mipsPkg::regAddrT debugWbRfWnum,
    output mipsPkg::dataT    debugWbRfWdata
);
    import mipsPkg::*;

    logic       stallD;
    forwardSelE forwardA;
    forwardSelE forwardB;

    // D
    instrT      instrD;
    dataT       pcD;
    regAddrT    rsD;
    regAddrT    rtD;
    regAddrT    destD;
    logic       regWriteEnD;
    aluOpE      aluOpD;
    logic       aluSrcImmD;
    dataT       immD;
    logic [4:0] shamtD;
    memOpE      memOpD;
    dataT       rsValueD;
    dataT       rtValueD;

    // E
    dataT       pcE;
    regAddrT    rsE;
    regAddrT    rtE;
    regAddrT    destE;
    logic       regWriteEnE;
    aluOpE      aluOpEx;
    logic       aluSrcImmE;
    dataT       immE;
    logic [4:0] shamtE;
    memOpE      memOpEx;
    dataT       rsValueE;
    dataT       rtValueE;
    dataT       aluResultE;
    dataT       storeDataE;

    // M
    dataT       pcM;
    regAddrT    destM;
    logic       regWriteEnM;
    memOpE      memOpM;
    dataT       aluResultM;
    dataT       storeDataM;
    dataT       resultM;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcF <= resetPc;
        end else if (!stallD) begin
            pcF <= pcF + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD <= '0;  // sll r0,r0,0
        end else if (!stallD) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
    end

    instDecoder decoder_i (
        .instr      (instrD),
        .rsAddr     (rsD),
        .rtAddr     (rtD),
        .destAddr   (destD),
        .regWriteEn (regWriteEnD),
        .aluOp      (aluOpD),
        .aluSrcImm  (aluSrcImmD),
        .imm        (immD),
        .shamt      (shamtD),
        .memOp      (memOpD)
    );

    regFile regFile_i (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (rsD),
        .readAddrB (rtD),
        .writeAddr (destM),
        .writeEn   (regWriteEnM),
        .writeData (resultM),
        .readDataA (rsValueD),
        .readDataB (rtValueD)
    );

    // a stall turns the D/E slot into a bubble
    always_ff @(posedge clk) begin
        if (!rstN || stallD) begin
            regWriteEnE <= 1'b0;
            memOpEx     <= memNone;
        end else begin
            regWriteEnE <= regWriteEnD;
            memOpEx     <= memOpD;
        end
    end

    always_ff @(posedge clk) begin
        pcE        <= pcD;
        rsE        <= rsD;
        rtE        <= rtD;
        destE      <= destD;
        aluOpEx    <= aluOpD;
        aluSrcImmE <= aluSrcImmD;
        immE       <= immD;
        shamtE     <= shamtD;
        rsValueE   <= rsValueD;
        rtValueE   <= rtValueD;
    end

    hazardUnit hazard_i (
        .rsD         (rsD),
        .rtD         (rtD),
        .rsE         (rsE),
        .rtE         (rtE),
        .destE       (destE),
        .destM       (destM),
        .memOpE      (memOpEx),
        .regWriteEnE (regWriteEnE),
        .regWriteEnM (regWriteEnM),
        .stallD      (stallD),
        .forwardA    (forwardA),
        .forwardB    (forwardB)
    );

    aluExecute execute_i (
        .rsValue   (rsValueE),
        .rtValue   (rtValueE),
        .resultM   (resultM),
        .imm       (immE),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .aluOp     (aluOpEx),
        .aluSrcImm (aluSrcImmE),
        .shamt     (shamtE),
        .aluResult (aluResultE),
        .storeData (storeDataE)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteEnM <= 1'b0;
            memOpM      <= memNone;
        end else begin
            regWriteEnM <= regWriteEnE;
            memOpM      <= memOpEx;
        end
    end

    always_ff @(posedge clk) begin
        pcM        <= pcE;
        destM      <= destE;
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
    end

    memAccess memAccess_i (
        .memOp     (memOpM),
        .aluResult (aluResultM),
        .storeData (storeDataM),
        .memRdata  (memRdata),
        .memEn     (memEn),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .result    (resultM),
        .memWen    (memWen)
    );

    // commit trace comes straight from M
    assign debugWbPc      = pcM;
    assign debugWbRfWen   = {4{regWriteEnM}};
    assign debugWbRfWnum  = destM;
    assign debugWbRfWdata = resultM;
endmodule

//--- coreDatapath_sva.sv
module coreDatapath_sva (
    input logic             clk,
    input logic             rstN,
    input mipsPkg::dataT    pcF,
    input logic             memEn,
    input mipsPkg::dataT    memAddr,
    input mipsPkg::byteEnT  memWen,
    input mipsPkg::byteEnT  debugWbRfWen,
    input mipsPkg::regAddrT debugWbRfWnum
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    strobeNeedsEnable: assert property (@(posedge clk) disable iff (!rstN)
        memWen != '0 |-> memEn)
    else begin
        failCount++;
        $error("memWen %b raised without memEn", memWen);
    end

    wordStoreAligned: assert property (@(posedge clk) disable iff (!rstN)
        memWen == 4'b1111 |-> memAddr[1:0] == 2'b00)
    else begin
        failCount++;
        $error("word store to unaligned address %h", memAddr);
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pcF[1:0] == 2'b00)
    else begin
        failCount++;
        $error("pcF %h not word aligned", pcF);
    end

    // r0 is never a commit target
    commitNotZero: assert property (@(posedge clk) disable iff (!rstN)
        debugWbRfWen != '0 |-> debugWbRfWnum != '0)
    else begin
        failCount++;
        $error("commit trace names register 0");
    end
endmodule

bind coreDatapath coreDatapath_sva sva_i (.*);

//--- coreDatapath_tb.sv
module coreDatapath_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int progLen = 300;
    localparam int watchdogCycles = 4 * progLen + 100;
    localparam dataT endPc = dataT'(4 * (progLen + 8));  // well past the last instruction
    localparam logic [5:0] fnTable [11] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                                             fnSlt, fnSltu, fnSll, fnSrl, fnSra};
    localparam logic [5:0] opTable [11] = '{opAddiu, opAndi, opOri, opXori, opSlti, opLui,
                                             opLw, opLb, opLbu, opSw, opSb};

    logic    clk = 1'b0;
    logic    rstN;
    dataT    instrF;
    dataT    memRdata;
    dataT    pcF;
    logic    memEn;
    dataT    memAddr;
    dataT    memWdata;
    byteEnT  memWen;
    dataT    debugWbPc;
    byteEnT  debugWbRfWen;
    regAddrT debugWbRfWnum;
    dataT    debugWbRfWdata;

    instrT   imem [512];
    dataT    dmem [64];
    dataT    memModel [64];
    dataT    modelReg [32];
    dataT    expPc [$];
    regAddrT expReg [$];
    dataT    expData [$];
    int      errors = 0;
    int      commitCount = 0;
    int      expTotal = 0;
    logic    seenCommit = 1'b0;
    dataT    lastPc = '0;

    coreDatapath #(.resetPc(32'h0)) dut_i (.*);

    always #5 clk = ~clk;

    assign instrF   = imem[pcF[10:2]];
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memEn) begin
            for (int l = 0; l < 4; l++) begin
                if (memWen[l]) begin
                    dmem[memAddr[7:2]][8*l +: 8] <= memWdata[8*l +: 8];
                end
            end
        end
    end

    function automatic regAddrT pickReg();
        return regAddrT'($urandom % 6);  // small set gives many back-to-back deps
    endfunction

    function automatic dataT fillWord(input int idx);
        return (dataT'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic compareValue(input string name, input dataT got, input dataT exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expectIdle();
        compareValue("memEn", dataT'(memEn), '0);
        compareValue("memWen", dataT'(memWen), '0);
        compareValue("debugWbRfWen", dataT'(debugWbRfWen), '0);
        compareValue("pcF", pcF, 32'h0);
    endtask

    // random instruction plus sequential reference execution
    task automatic addInstr(input int idx);
        int          kind;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        regAddrT     dest;
        logic [15:0] im;
        logic [4:0]  sh;
        dataT        a;
        dataT        b;
        dataT        res;
        dataT        sext;
        logic [7:0]  byteVal;
        kind = int'($urandom % 22);
        rs   = pickReg();
        rt   = pickReg();
        rd   = pickReg();
        sh   = 5'($urandom);
        im   = 16'($urandom);
        if (kind == 8 || kind == 9 || kind == 10 || kind >= 16) begin
            rs = '0;  // shifts, lui, and r0 as load/store base
        end
        if (kind == 17 || kind == 20) begin
            im = 16'(($urandom % 64) * 4);
        end else if (kind >= 18) begin
            im = 16'($urandom % 256);
        end
        a       = modelReg[rs];
        b       = modelReg[rt];
        sext    = {{16{im[15]}}, im};
        byteVal = memModel[im[7:2]][{im[1:0], 3'b000} +: 8];
        if (kind <= 10) begin
            imem[idx] = {opSpecial, rs, rt, rd, (kind >= 8) ? sh : 5'd0, fnTable[kind]};
        end else begin
            imem[idx] = {opTable[kind - 11], rs, rt, im};
        end
        res = '0;
        case (kind)
            0:  res = a + b;
            1:  res = a - b;
            2:  res = a & b;
            3:  res = a | b;
            4:  res = a ^ b;
            5:  res = ~(a | b);
            6:  res = {31'b0, $signed(a) < $signed(b)};
            7:  res = {31'b0, a < b};
            8:  res = b << sh;
            9:  res = b >> sh;
            10: res = dataT'($signed(b) >>> sh);
            11: res = a + sext;
            12: res = a & {16'h0, im};
            13: res = a | {16'h0, im};
            14: res = a ^ {16'h0, im};
            15: res = {31'b0, $signed(a) < $signed(sext)};
            16: res = {im, 16'h0};
            17: res = memModel[im[7:2]];
            18: res = {{24{byteVal[7]}}, byteVal};
            19: res = {24'h0, byteVal};
            20: memModel[im[7:2]] = b;
            21: memModel[im[7:2]][{im[1:0], 3'b000} +: 8] = b[7:0];
            default: res = '0;
        endcase
        dest = (kind <= 10) ? rd : rt;
        if (kind < 20 && dest != '0) begin
            modelReg[dest] = res;
            expPc.push_back(dataT'(4 * idx));
            expReg.push_back(dest);
            expData.push_back(res);
        end
    endtask

    task automatic matchCommit();
        dataT    pc;
        regAddrT num;
        dataT    data;
        commitCount++;
        compareValue("debugWbRfWen", dataT'(debugWbRfWen), 32'hf);
        assert (debugWbRfWnum != '0) else begin
            errors++;
            $display("[ERROR] %0t a commit names register 0", $time);
        end
        assert (!seenCommit || debugWbPc > lastPc) else begin
            errors++;
            $display("[ERROR] %0t commit pc %h does not rise past %h", $time, debugWbPc, lastPc);
        end
        seenCommit = 1'b1;
        lastPc     = debugWbPc;
        assert (expPc.size() != 0) else begin
            errors++;
            $display("[ERROR] %0t commit at pc %h with no write left in the model", $time,
                     debugWbPc);
        end
        if (expPc.size() != 0) begin
            pc   = expPc.pop_front();
            num  = expReg.pop_front();
            data = expData.pop_front();
            compareValue("debugWbPc", debugWbPc, pc);
            compareValue("debugWbRfWnum", dataT'(debugWbRfWnum), dataT'(num));
            compareValue("debugWbRfWdata", debugWbRfWdata, data);
        end
    endtask

    always @(negedge clk) begin
        if (!rstN) begin
            expectIdle();
        end else if (debugWbRfWen != '0) begin
            matchCommit();
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: the program did not drain within %0d cycles", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(32'h7416_8619));
        rstN = 1'b0;
        for (int i = 0; i < 512; i++) begin
            imem[i] = '0;  // nop padding
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]     <= fillWord(i);
            memModel[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            modelReg[i] = '0;
        end
        for (int i = 0; i < progLen; i++) begin
            addInstr(i);
        end
        expTotal = expPc.size();
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        @(negedge clk);
        expectIdle();  // first cycle out of reset
        while (pcF < endPc) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        for (int i = 0; i < 64; i++) begin
            compareValue($sformatf("dmem[%0d]", i), dmem[i], memModel[i]);
        end
        compareValue("commitCount", dataT'(commitCount), dataT'(expTotal));
        total = errors + dut_i.sva_i.failCount;
        $display("checks done: %0d errors, %0d assertion failures, %0d of %0d commits",
                 errors, dut_i.sva_i.failCount, commitCount, expTotal);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

//--- verilog.f
mipsPkg.sv
instDecoder.sv
regFile.sv
hazardUnit.sv
aluExecute.sv
memAccess.sv
coreDatapath.sv
coreDatapath_sva.sv
coreDatapath_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module coreDatapath_tb -f verilog.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
